// ==== src/mem_stage_pkg.sv ====
`default_nettype none

package mem_stage_pkg;

    ////////////////////
    // datapath widths
    ////////////////////

    localparam int xlen       = 32; // data and address width
    localparam int wb_ctrl_w  = 3;  // write-back control bundle
    localparam int reg_addr_w = 5;  // register number

    ////////////////////
    // vic register map
    ////////////////////

    localparam int conf_w      = 4; // one config register
    localparam int conf_addr_w = 5; // window index, also low address bits
    localparam int prio_w      = 3; // priority field, bits 2..0
    localparam int conf_en_bit = 3; // enable lives above priority

    // upper address bits that pick the window
    localparam int vic_tag_w = xlen - conf_addr_w;

    // window base sits at 0x0003_0000 in byte space
    localparam logic [vic_tag_w-1:0] vic_region_tag = 27'h1800;

    // mem_out layout for a vic read
    // config in the low nibble, rest zero
    localparam int vic_pad_w = xlen - conf_w;

endpackage

`default_nettype wire

// ==== src/memory_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_access (
    input  wire                                     Clk,
    input  wire                                     rst_n,
    // from ex/ma pipeline register
    input  wire                                     ma_en,       // access enable
    input  wire                                     ma_rw,       // 1 = store
    input  wire  [mem_stage_pkg::xlen-1:0]          alu_result,  // effective address
    input  wire  [mem_stage_pkg::xlen-1:0]          rs2_val,
    input  wire  [mem_stage_pkg::xlen-1:0]          fwd_wb_val,  // forwarded from wb
    input  wire                                     fwd_sel,     // from forwarding unit
    input  wire  [mem_stage_pkg::wb_ctrl_w-1:0]     wb_ctrl_in,
    input  wire  [mem_stage_pkg::xlen-1:0]          pc_in,
    input  wire  [mem_stage_pkg::reg_addr_w-1:0]    rdst_in,
    input  wire  [mem_stage_pkg::reg_addr_w-1:0]    rs2_addr_in,
    // return paths
    input  wire  [mem_stage_pkg::xlen-1:0]          ram_rdata,
    input  wire                                     miss,
    input  wire  [mem_stage_pkg::conf_w-1:0]        vic_rdata,
    // to ma/wb pipeline register
    output logic [mem_stage_pkg::wb_ctrl_w-1:0]     wb_ctrl_out,
    output logic [mem_stage_pkg::xlen-1:0]          pc_out,
    output logic [mem_stage_pkg::reg_addr_w-1:0]    rdst_out,
    output logic [mem_stage_pkg::xlen-1:0]          alu_result_out,
    output logic [mem_stage_pkg::reg_addr_w-1:0]    rs2_addr_out, // to forwarding unit
    output logic [1:0]                              ma_out,       // {rw, ram_en}
    output logic [mem_stage_pkg::xlen-1:0]          mem_out,
    output logic                                    miss_out,
    // ram side
    output logic                                    ram_en,
    output logic                                    ram_rw,
    output logic [mem_stage_pkg::xlen-1:0]          ram_addr,
    output logic [mem_stage_pkg::xlen-1:0]          ram_wdata,
    // vic config port
    output logic                                    vic_we,
    output logic [mem_stage_pkg::conf_addr_w-1:0]   vic_index,
    output logic [mem_stage_pkg::conf_w-1:0]        vic_wdata
);

    import mem_stage_pkg::*;

    logic [xlen-1:0]   store_data;  // selected store operand
    logic              in_vic_win;  // enabled access hits the vic window
    logic              vic_rd;      // vic load this cycle
    logic              vic_rd_sel;  // last access was a vic load
    logic [conf_w-1:0] vic_rd_q;    // config captured at the load

    ////////////////////
    // pass-through
    ////////////////////

    assign wb_ctrl_out    = wb_ctrl_in;
    assign pc_out         = pc_in;
    assign rdst_out       = rdst_in;
    assign alu_result_out = alu_result;
    assign rs2_addr_out   = rs2_addr_in;
    assign miss_out       = miss;      // ram flag, already registered

    // store data from reg file or wb forward
    assign store_data = fwd_sel ? fwd_wb_val : rs2_val;

    ////////////////////
    // address decode
    ////////////////////

    assign in_vic_win = ma_en && (alu_result[xlen-1:conf_addr_w] == vic_region_tag);
    assign vic_rd     = in_vic_win && !ma_rw;

    assign ram_en    = ma_en && !in_vic_win; // everything outside the window
    assign ram_rw    = ma_rw;
    assign ram_addr  = alu_result;
    assign ram_wdata = store_data;

    assign vic_we    = in_vic_win && ma_rw;                 // single-cycle strobe
    assign vic_index = alu_result[conf_addr_w-1:0];
    assign vic_wdata = store_data[conf_w-1:0];              // only the low nibble matters

    // forwarding unit wants the write bit and the real ram enable
    assign ma_out = {ma_rw, ram_en};

    ////////////////////
    // read source select
    ////////////////////

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            vic_rd_sel <= 1'b0;
        end else begin
            vic_rd_sel <= vic_rd;
        end
    end

    // hold the readback so the next address cannot disturb it
    always_ff @(posedge Clk) begin
        if (vic_rd) begin
            vic_rd_q <= vic_rdata;
        end
    end

    assign mem_out = vic_rd_sel ? {{vic_pad_w{1'b0}}, vic_rd_q} : ram_rdata;

endmodule

`default_nettype wire

// ==== src/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int ram_depth = 256 // words
) (
    input  wire                             Clk,
    input  wire                             rst_n,
    input  wire                             ram_en,
    input  wire                             ram_rw,    // 1 = write
    input  wire  [mem_stage_pkg::xlen-1:0]  ram_addr,  // byte address
    input  wire  [mem_stage_pkg::xlen-1:0]  ram_wdata,
    output logic [mem_stage_pkg::xlen-1:0]  ram_rdata, // valid cycle after read
    output logic                            miss       // one cycle, out of range
);

    import mem_stage_pkg::*;

    localparam int idx_w = (ram_depth > 1) ? $clog2(ram_depth) : 1;

    // depth at word-index width for the range check
    localparam logic [xlen-3:0] depth_lim = (xlen-2)'(ram_depth);

    logic [xlen-1:0]  mem [ram_depth];

    logic [xlen-3:0]  word_idx;  // byte address minus the lane bits
    logic             in_range;
    logic [idx_w-1:0] arr_idx;
    logic             do_wr;
    logic             do_rd;

    assign word_idx = ram_addr[xlen-1:2];
    assign in_range = (word_idx < depth_lim);
    assign arr_idx  = word_idx[idx_w-1:0];

    assign do_wr = ram_en && ram_rw && in_range;
    assign do_rd = ram_en && !ram_rw;

    ////////////////////
    // array write
    ////////////////////

    always_ff @(posedge Clk) begin
        if (do_wr) begin
            mem[arr_idx] <= ram_wdata;
        end
    end

    ////////////////////
    // read + miss
    ////////////////////

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            ram_rdata <= '0;
            miss      <= 1'b0;
        end else begin
            miss <= ram_en && !in_range; // loads and stores alike
            if (do_rd) begin
                // out-of-range load returns zero, array untouched
                ram_rdata <= in_range ? mem[arr_idx] : '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/vic_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_channel #(
    parameter int chan_index = 0 // this channel's slot in the window
) (
    input  wire                                     Clk,
    input  wire                                     rst_n,
    input  wire                                     vic_we,
    input  wire  [mem_stage_pkg::conf_addr_w-1:0]   vic_index,
    input  wire  [mem_stage_pkg::conf_w-1:0]        vic_wdata,
    input  wire                                     irq_line,  // raw source
    input  wire                                     ack,       // from collector
    output logic [mem_stage_pkg::conf_w-1:0]        conf,      // {en, prio}
    output logic                                    pending
);

    import mem_stage_pkg::*;

    localparam logic [conf_addr_w-1:0] my_index = conf_addr_w'(chan_index);

    logic sel;      // config write aimed here
    logic irq_q;    // previous line sample
    logic irq_rise;

    assign sel      = vic_we && (vic_index == my_index);
    assign irq_rise = irq_line && !irq_q;

    ////////////////////
    // config register
    ////////////////////

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            conf <= '0; // disabled, prio 0
        end else if (sel) begin
            conf <= vic_wdata;
        end
    end

    ////////////////////
    // edge detect + pending
    ////////////////////

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q   <= 1'b0;
            pending <= 1'b0;
        end else begin
            irq_q <= irq_line;
            // a new edge beats a same-cycle ack
            if (irq_rise) begin
                pending <= 1'b1;
            end else if (ack) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/vic_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_collector #(
    parameter int num_channels = 8
) (
    input  wire  [num_channels*mem_stage_pkg::conf_w-1:0] conf_bus,    // flattened configs
    input  wire  [num_channels-1:0]                       pending_bus,
    input  wire  [mem_stage_pkg::conf_addr_w-1:0]         vic_index,   // readback select
    input  wire                                           irq_ack,     // one-cycle pulse
    output logic [mem_stage_pkg::conf_w-1:0]              vic_rdata,
    output logic                                          irq_req,
    output logic [mem_stage_pkg::conf_addr_w-1:0]         irq_id,
    output logic [num_channels-1:0]                       ack_vec      // one-hot
);

    import mem_stage_pkg::*;

    logic [conf_w-1:0] conf_arr [num_channels];
    logic [prio_w-1:0] best_prio;

    // unpack the bus per channel
    for (genvar g = 0; g < num_channels; g++) begin : g_unpack
        assign conf_arr[g] = conf_bus[g*conf_w +: conf_w];
    end

    ////////////////////
    // priority resolve
    ////////////////////

    always_comb begin
        irq_req   = 1'b0;
        irq_id    = '0;
        best_prio = '0;
        for (int i = 0; i < num_channels; i++) begin
            if (pending_bus[i] && conf_arr[i][conf_en_bit]) begin
                // strict compare keeps the lower index on a tie
                if (!irq_req || (conf_arr[i][prio_w-1:0] > best_prio)) begin
                    irq_req   = 1'b1;
                    irq_id    = conf_addr_w'(i);
                    best_prio = conf_arr[i][prio_w-1:0];
                end
            end
        end
    end

    ////////////////////
    // ack decode + readback
    ////////////////////

    always_comb begin
        ack_vec   = '0;
        vic_rdata = '0; // unpopulated slots read zero
        for (int i = 0; i < num_channels; i++) begin
            // ack only retires a real winner
            ack_vec[i] = irq_ack && irq_req && (irq_id == conf_addr_w'(i));
            if (vic_index == conf_addr_w'(i)) begin
                vic_rdata = conf_arr[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/mem_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top #(
    parameter int num_channels = 8,   // 1..32
    parameter int ram_depth    = 256  // words
) (
    input  wire                                     Clk,
    input  wire                                     rst_n,
    // pipeline in
    input  wire                                     ma_en,
    input  wire                                     ma_rw,
    input  wire  [mem_stage_pkg::xlen-1:0]          alu_result,
    input  wire  [mem_stage_pkg::xlen-1:0]          rs2_val,
    input  wire  [mem_stage_pkg::xlen-1:0]          fwd_wb_val,
    input  wire                                     fwd_sel,
    input  wire  [mem_stage_pkg::wb_ctrl_w-1:0]     wb_ctrl_in,
    input  wire  [mem_stage_pkg::xlen-1:0]          pc_in,
    input  wire  [mem_stage_pkg::reg_addr_w-1:0]    rdst_in,
    input  wire  [mem_stage_pkg::reg_addr_w-1:0]    rs2_addr_in,
    // pipeline out
    output logic [mem_stage_pkg::wb_ctrl_w-1:0]     wb_ctrl_out,
    output logic [mem_stage_pkg::xlen-1:0]          pc_out,
    output logic [mem_stage_pkg::reg_addr_w-1:0]    rdst_out,
    output logic [mem_stage_pkg::xlen-1:0]          alu_result_out,
    output logic [mem_stage_pkg::reg_addr_w-1:0]    rs2_addr_out,
    output logic [1:0]                              ma_out,
    output logic [mem_stage_pkg::xlen-1:0]          mem_out,
    output logic                                    miss_out,
    // interrupts
    input  wire  [num_channels-1:0]                 irq_lines,
    input  wire                                     irq_ack,
    output logic                                    irq_req,
    output logic [mem_stage_pkg::conf_addr_w-1:0]   irq_id
);

    import mem_stage_pkg::*;

    // stage <-> ram
    logic                   ram_en;
    logic                   ram_rw;
    logic [xlen-1:0]        ram_addr;
    logic [xlen-1:0]        ram_wdata;
    logic [xlen-1:0]        ram_rdata;
    logic                   miss;

    // stage <-> vic
    logic                   vic_we;
    logic [conf_addr_w-1:0] vic_index;
    logic [conf_w-1:0]      vic_wdata;
    logic [conf_w-1:0]      vic_rdata;

    // channels <-> collector
    logic [num_channels*conf_w-1:0] conf_bus;
    logic [num_channels-1:0]        pending_bus;
    logic [num_channels-1:0]        ack_vec;

    memory_access memory_access_i (
        .Clk            (Clk),
        .rst_n          (rst_n),
        .ma_en          (ma_en),
        .ma_rw          (ma_rw),
        .alu_result     (alu_result),
        .rs2_val        (rs2_val),
        .fwd_wb_val     (fwd_wb_val),
        .fwd_sel        (fwd_sel),
        .wb_ctrl_in     (wb_ctrl_in),
        .pc_in          (pc_in),
        .rdst_in        (rdst_in),
        .rs2_addr_in    (rs2_addr_in),
        .ram_rdata      (ram_rdata),
        .miss           (miss),
        .vic_rdata      (vic_rdata),
        .wb_ctrl_out    (wb_ctrl_out),
        .pc_out         (pc_out),
        .rdst_out       (rdst_out),
        .alu_result_out (alu_result_out),
        .rs2_addr_out   (rs2_addr_out),
        .ma_out         (ma_out),
        .mem_out        (mem_out),
        .miss_out       (miss_out),
        .ram_en         (ram_en),
        .ram_rw         (ram_rw),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata),
        .vic_we         (vic_we),
        .vic_index      (vic_index),
        .vic_wdata      (vic_wdata)
    );

    data_ram #(
        .ram_depth (ram_depth)
    ) data_ram_i (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .ram_en    (ram_en),
        .ram_rw    (ram_rw),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata),
        .miss      (miss)
    );

    ////////////////////
    // vic channels
    ////////////////////

    for (genvar i = 0; i < num_channels; i++) begin : g_chan
        vic_channel #(
            .chan_index (i)
        ) vic_channel_i (
            .Clk       (Clk),
            .rst_n     (rst_n),
            .vic_we    (vic_we),
            .vic_index (vic_index),
            .vic_wdata (vic_wdata),
            .irq_line  (irq_lines[i]),
            .ack       (ack_vec[i]),
            .conf      (conf_bus[i*conf_w +: conf_w]),
            .pending   (pending_bus[i])
        );
    end

    vic_collector #(
        .num_channels (num_channels)
    ) vic_collector_i (
        .conf_bus    (conf_bus),
        .pending_bus (pending_bus),
        .vic_index   (vic_index),
        .irq_ack     (irq_ack),
        .vic_rdata   (vic_rdata),
        .irq_req     (irq_req),
        .irq_id      (irq_id),
        .ack_vec     (ack_vec)
    );

endmodule

`default_nettype wire

// ==== tests/mem_subsystem_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_assertions #(
    parameter int num_channels = 8,
    parameter int ram_depth    = 256
) (
    input wire                                   Clk,
    input wire                                   rst_n,
    input wire                                   ram_en,
    input wire                                   vic_we,
    input wire [mem_stage_pkg::xlen-1:0]         ram_addr,
    input wire                                   miss,
    input wire                                   irq_req,
    input wire [mem_stage_pkg::conf_addr_w-1:0]  irq_id
);

    import mem_stage_pkg::*;

    logic oor_acc; // enabled ram access past the last word

    assign oor_acc = ram_en && (ram_addr[xlen-1:2] >= (xlen-2)'(ram_depth));

    ////////////////////
    // access steering
    ////////////////////

    a_one_target: assert property (@(posedge Clk) disable iff (!rst_n)
        !(ram_en && vic_we))
        else $error("ram_en and vic_we high in the same cycle");

    a_irq_id_range: assert property (@(posedge Clk) disable iff (!rst_n)
        irq_req |-> (int'(irq_id) < num_channels))
        else $error("irq_id names a channel that does not exist");

    // miss lags its access by one edge
    a_miss_pair: assert property (@(posedge Clk) disable iff (!rst_n)
        (miss && $past(miss)) |-> ($past(oor_acc) && $past(oor_acc, 2)))
        else $error("miss high twice without two out-of-range accesses");

endmodule

`default_nettype wire

// ==== tests/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;

    localparam int num_channels = 8;
    localparam int ram_depth    = 256;

    // window tag 0x1800 sits above the five index bits
    localparam logic [31:0] vic_base = 32'h0003_0000;

    logic                    Clk;
    logic                    rst_n;
    logic                    ma_en;
    logic                    ma_rw;
    logic [31:0]             alu_result;
    logic [31:0]             rs2_val;
    logic [31:0]             fwd_wb_val;
    logic                    fwd_sel;
    logic [2:0]              wb_ctrl_in;
    logic [31:0]             pc_in;
    logic [4:0]              rdst_in;
    logic [4:0]              rs2_addr_in;
    logic [2:0]              wb_ctrl_out;
    logic [31:0]             pc_out;
    logic [4:0]              rdst_out;
    logic [31:0]             alu_result_out;
    logic [4:0]              rs2_addr_out;
    logic [1:0]              ma_out;       // {rw, ram_en}
    logic [31:0]             mem_out;
    logic                    miss_out;
    logic [num_channels-1:0] irq_lines;
    logic                    irq_ack;
    logic                    irq_req;
    logic [4:0]              irq_id;

    // reference model
    logic [31:0]             ram_model  [ram_depth];
    logic [3:0]              conf_model [num_channels]; // {en, prio}
    logic [num_channels-1:0] pend_model;
    integer                  seed;

    mem_subsystem_top #(
        .num_channels (num_channels),
        .ram_depth    (ram_depth)
    ) mem_subsystem_i (.*);

    bind mem_subsystem_top mem_subsystem_assertions #(
        .num_channels (num_channels),
        .ram_depth    (ram_depth)
    ) mem_subsystem_assertions_i (
        .Clk      (Clk),
        .rst_n    (rst_n),
        .ram_en   (ram_en),
        .vic_we   (vic_we),
        .ram_addr (ram_addr),
        .miss     (miss),
        .irq_req  (irq_req),
        .irq_id   (irq_id)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk; // 4 ns period
    end

    ////////////////////
    // error paths
    ////////////////////

    task automatic stop_run(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_error(input string msg);
        stop_run($sformatf("[FAIL] %0t ns: %s", $time, msg));
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        assert (actual === expected)
            else report_error($sformatf("%s is %h, expected %h", what, actual, expected));
    endtask

    ////////////////////
    // stimulus helpers
    ////////////////////

    // one access from a falling edge, returns at the next falling edge
    task automatic issue_access(input logic rw, input logic [31:0] addr,
                                input logic [31:0] data, input logic use_fwd);
        logic in_win;
        in_win      = (addr[31:5] == vic_base[31:5]);
        ma_en       = 1'b1;
        ma_rw       = rw;
        alu_result  = addr;
        fwd_sel     = use_fwd;
        rs2_val     = use_fwd ? ~data : data; // unused source carries junk
        fwd_wb_val  = use_fwd ? data : ~data;
        wb_ctrl_in  = 3'($random(seed));
        pc_in       = $random(seed);
        rdst_in     = 5'($random(seed));
        rs2_addr_in = 5'($random(seed));
        #1; // combinational settle
        check_value(32'(wb_ctrl_out), 32'(wb_ctrl_in), "wb_ctrl_out");
        check_value(pc_out, pc_in, "pc_out");
        check_value(32'(rdst_out), 32'(rdst_in), "rdst_out");
        check_value(alu_result_out, addr, "alu_result_out");
        check_value(32'(rs2_addr_out), 32'(rs2_addr_in), "rs2_addr_out");
        check_value(32'(ma_out), 32'({rw, !in_win}), "ma_out"); // ram_en off in window
        @(negedge Clk);
        ma_en = 1'b0;
        ma_rw = 1'b0;
    endtask

    task automatic write_conf(input int chan, input logic [3:0] val);
        issue_access(1'b1, vic_base | 32'(chan), {28'h0, val}, 1'b0);
        conf_model[chan] = val;
    endtask

    task automatic pulse_lines(input logic [num_channels-1:0] mask);
        irq_lines = mask;
        @(negedge Clk); // high sample lands on the edge between
        irq_lines  = '0;
        pend_model = pend_model | mask;
    endtask

    // highest priority among pending and enabled, lowest index on a tie
    function automatic int model_winner();
        int best;
        best = -1;
        for (int i = 0; i < num_channels; i++) begin
            if (pend_model[i] && conf_model[i][3]) begin
                if (best < 0 || conf_model[i][2:0] > conf_model[best][2:0]) begin
                    best = i;
                end
            end
        end
        return best;
    endfunction

    // request is combinational, so it shows in the cycle after the edge
    task automatic check_irq(input string what);
        int win;
        win = model_winner();
        if (win < 0) begin
            check_value(32'(irq_req), 32'h0, $sformatf("%s, irq_req", what));
        end else begin
            check_value(32'(irq_req), 32'h1, $sformatf("%s, irq_req", what));
            check_value(32'(irq_id), 32'(win), $sformatf("%s, irq_id", what));
        end
    endtask

    task automatic ack_winner();
        int win;
        win = model_winner();
        irq_ack = 1'b1;
        @(negedge Clk);
        irq_ack = 1'b0;
        if (win >= 0) begin
            pend_model[win] = 1'b0;
        end
    endtask

    task automatic drain_pending();
        int n;
        n = 0;
        while (model_winner() >= 0) begin
            if (n == 2 * num_channels) begin
                stop_run("acknowledge loop did not retire the pending sources");
            end
            check_irq("before acknowledge");
            ack_winner();
            n++;
        end
        check_irq("after last acknowledge");
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic test_store_load();
        int          idx [16];
        logic [31:0] word;
        for (int i = 0; i < 16; i++) begin
            idx[i] = $random(seed) & (ram_depth - 1);
            word   = $random(seed);
            issue_access(1'b1, 32'(idx[i]) << 2, word, i[0]); // sources alternate
            ram_model[idx[i]] = word;
        end
        for (int i = 0; i < 16; i++) begin
            issue_access(1'b0, 32'(idx[i]) << 2, 32'h0, 1'b0);
            check_value(mem_out, ram_model[idx[i]], "load data");
            check_value(32'(miss_out), 32'h0, "miss_out on in-range load");
        end
    endtask

    task automatic test_out_of_range();
        logic [31:0] keep;
        keep = $random(seed);
        issue_access(1'b1, 32'd5 << 2, keep, 1'b0);
        ram_model[5] = keep;
        // same low index bits as word 5, one depth up
        issue_access(1'b1, 32'(ram_depth + 5) << 2, ~keep, 1'b1);
        check_value(32'(miss_out), 32'h1, "miss_out after out-of-range store");
        @(negedge Clk);
        check_value(32'(miss_out), 32'h0, "miss_out one cycle after store miss");
        issue_access(1'b0, 32'h0000_4000, 32'h0, 1'b0); // word 4096
        check_value(mem_out, 32'h0, "out-of-range load data");
        check_value(32'(miss_out), 32'h1, "miss_out after out-of-range load");
        @(negedge Clk);
        check_value(32'(miss_out), 32'h0, "miss_out one cycle after load miss");
        issue_access(1'b0, 32'd5 << 2, 32'h0, 1'b0);
        check_value(mem_out, ram_model[5], "word 5 after aliased store");
    endtask

    task automatic test_vic_config();
        logic [31:0] data;
        for (int w = 0; w < 8; w++) begin  // ram words under the same low bits
            data = $random(seed);
            issue_access(1'b1, 32'(w) << 2, data, 1'b0);
            ram_model[w] = data;
        end
        for (int c = 0; c < num_channels; c++) begin
            data = $random(seed); // only the nibble lands
            issue_access(1'b1, vic_base | 32'(c), data, c[0]);
            conf_model[c] = data[3:0];
        end
        for (int c = 0; c < 32; c++) begin
            issue_access(1'b0, vic_base | 32'(c), 32'h0, 1'b0);
            if (c < num_channels) begin
                check_value(mem_out, 32'(conf_model[c]), "vic config readback");
            end else begin
                check_value(mem_out, 32'h0, "unpopulated vic slot");
            end
        end
        for (int w = 0; w < 8; w++) begin
            issue_access(1'b0, 32'(w) << 2, 32'h0, 1'b0);
            check_value(mem_out, ram_model[w], "ram word beside vic window");
        end
        check_irq("after config writes");
    endtask

    task automatic test_priority();
        logic [num_channels-1:0] mask;
        write_conf(3, 4'b0111); // top priority but disabled
        write_conf(6, 4'b1001);
        pulse_lines(8'b0000_1000);
        check_irq("disabled source alone");
        pulse_lines(8'b0100_0000);
        check_irq("disabled against enabled");
        drain_pending();
        for (int r = 0; r < 6; r++) begin
            for (int c = 0; c < num_channels; c++) begin
                write_conf(c, 4'($random(seed)));
            end
            mask = num_channels'($random(seed));
            pulse_lines(mask);
            check_irq($sformatf("random round %0d", r));
            drain_pending();
        end
    endtask

    task automatic test_ack_sequence();
        logic [num_channels-1:0] held;
        for (int c = 0; c < num_channels; c++) begin
            write_conf(c, {1'b1, 3'($random(seed))});
        end
        held      = 8'b1011_0110;
        irq_lines = held; // stays high through the sequence
        @(negedge Clk);
        pend_model = pend_model | held;
        drain_pending();
        @(negedge Clk);
        check_value(32'(irq_req), 32'h0, "irq_req with lines still high");
        irq_lines = '0;
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        seed        = 43605;
        rst_n       = 1'b0;
        ma_en       = 1'b0;
        ma_rw       = 1'b0;
        alu_result  = '0;
        rs2_val     = '0;
        fwd_wb_val  = '0;
        fwd_sel     = 1'b0;
        wb_ctrl_in  = '0;
        pc_in       = '0;
        rdst_in     = '0;
        rs2_addr_in = '0;
        irq_lines   = '0;
        irq_ack     = 1'b0;
        pend_model  = '0;
        for (int c = 0; c < num_channels; c++) begin
            conf_model[c] = 4'h0;
        end
        repeat (4) @(posedge Clk);
        @(negedge Clk);
        rst_n = 1'b1;
        @(negedge Clk);
        check_value(32'(irq_req), 32'h0, "irq_req after reset");
        check_value(32'(miss_out), 32'h0, "miss_out after reset");
        check_value(32'(ma_out), 32'h0, "ma_out after reset");
        test_store_load();
        test_out_of_range();
        test_vic_config();
        test_priority();
        test_ack_sequence();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/mem_stage_pkg.sv
src/memory_access.sv
src/data_ram.sv
src/vic_channel.sv
src/vic_collector.sv
src/mem_subsystem_top.sv
tests/mem_subsystem_assertions.sv
tests/mem_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the memory subsystem testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module mem_subsystem_tb -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q '^>>> PASS$'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
